// ==== source/jstkPkg.sv ====
`default_nettype none

package jstkPkg;

	// ==================================================
	// SPI timing
	// ==================================================
	localparam int unsigned sclkHalfDiv = 4;      // CLK cycles per SCLK half period
	localparam int unsigned bitsPerByte = 8;

	// ==================================================
	// Joystick frame
	// ==================================================
	localparam int unsigned frameBytes = 5;       // X lo, X hi, Y lo, Y hi, buttons
	localparam int unsigned pollPeriod = 400;     // Short for simulation, must exceed a frame
	localparam logic [7:0] jstkCmd = 8'h80;       // Module LEDs off
	localparam int unsigned axisWidth = 10;

	// Byte request toward the SPI engine
	typedef struct packed {
		logic start;                              // One-cycle pulse
		logic [bitsPerByte-1:0] txByte;
	} spiByteReq;

	// Byte response from the SPI engine
	typedef struct packed {
		logic busy;
		logic done;                               // One-cycle pulse with rxByte valid
		logic [bitsPerByte-1:0] rxByte;
	} spiByteRsp;

	// One decoded joystick sample
	typedef struct packed {
		logic [axisWidth-1:0] xPos;
		logic [axisWidth-1:0] yPos;
		logic button;
		logic valid;                              // Pulses once per frame
	} jstkSample;

endpackage

`default_nettype wire

// ==== source/steerPkg.sv ====
`default_nettype none

package steerPkg;

	// ==================================================
	// Steering direction
	// ==================================================
	typedef enum logic [1:0] {
		straight = 2'b00,                         // Also the reset value
		left     = 2'b01,
		back     = 2'b10,
		right    = 2'b11
	} steerDir;

	// ==================================================
	// Classification thresholds
	// ==================================================
	// X axis, stick centre near 500
	localparam int unsigned leftMinX = 550;       // At or above gives left
	localparam int unsigned rightMaxX = 450;      // At or below gives right

	// Y band for side steering, inclusive
	localparam int unsigned bandMinY = 320;       // Below gives straight
	localparam int unsigned bandMaxY = 720;       // Above gives back

endpackage

`default_nettype wire

// ==== source/pollTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

// Periodic poll enable on CLK
module pollTimer (
	input wire CLK,
	input wire RST,
	output logic poll
);

	logic [$clog2(jstkPkg::pollPeriod)-1:0] cnt;   // Cycle counter
	logic wrap;

	always_comb wrap = (32'(cnt) == jstkPkg::pollPeriod - 1);

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			cnt <= '0;
			poll <= 1'b0;
		end else begin
			poll <= wrap;                              // Single-cycle pulse at wrap
			if (wrap) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/spiByteEngine.sv ====
`timescale 1ns/1ps
`default_nettype none

// SPI mode 0 master, one byte per start
module spiByteEngine (
	input wire CLK,
	input wire RST,
	input wire jstkPkg::spiByteReq req,
	input wire MISO,
	output jstkPkg::spiByteRsp rsp,
	output logic SCLK,
	output logic MOSI
);

	typedef enum logic [1:0] {
		stIdle,
		stShift,
		stFinish
	} engState;

	engState state;
	logic [$clog2(jstkPkg::sclkHalfDiv)-1:0] halfCnt;   // CLK cycles within half period
	logic [$clog2(jstkPkg::bitsPerByte)-1:0] bitCnt;    // Falling edges seen
	logic [jstkPkg::bitsPerByte-1:0] txSr;              // MSB drives MOSI
	logic [jstkPkg::bitsPerByte-1:0] rxSr;
	logic halfEnd;
	logic lastBit;

	// ==================================================
	// Edge timing
	// ==================================================
	always_comb begin
		halfEnd = (32'(halfCnt) == jstkPkg::sclkHalfDiv - 1);
		lastBit = (32'(bitCnt) == jstkPkg::bitsPerByte - 1);
	end

	// ==================================================
	// FSM, SCLK and transmit shifter
	// ==================================================
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state <= stIdle;
			halfCnt <= '0;
			bitCnt <= '0;
			SCLK <= 1'b0;                                 // SCLK idles low
			txSr <= '0;                                   // MOSI low until first byte
		end else begin
			case (state)
				stIdle: begin
					if (req.start) begin
						txSr <= req.txByte;                   // Bit 7 on MOSI before first rise
						halfCnt <= '0;
						bitCnt <= '0;
						state <= stShift;
					end
				end
				stShift: begin
					if (halfEnd) begin
						halfCnt <= '0;
						SCLK <= ~SCLK;
						if (SCLK) begin                        // This edge falls
							txSr <= {txSr[jstkPkg::bitsPerByte-2:0], 1'b0};
							bitCnt <= bitCnt + 1'b1;
							if (lastBit) begin
								state <= stFinish;                 // Eighth bit complete
							end
						end
					end else begin
						halfCnt <= halfCnt + 1'b1;
					end
				end
				stFinish: state <= stIdle;                 // done shows for one cycle
				default: state <= stIdle;
			endcase
		end
	end

	// Receive shifter, MISO taken as SCLK rises
	always_ff @(posedge CLK) begin
		if (state == stShift && halfEnd && !SCLK) begin
			rxSr <= {rxSr[jstkPkg::bitsPerByte-2:0], MISO};
		end
	end

	always_comb begin
		MOSI = txSr[jstkPkg::bitsPerByte-1];
		rsp.busy = (state == stShift);               // Falls as done rises
		rsp.done = (state == stFinish);
		rsp.rxByte = rxSr;
	end

endmodule

`default_nettype wire

// ==== source/jstkFrameCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

// Five-byte joystick frame under one slave select
module jstkFrameCtrl (
	input wire CLK,
	input wire RST,
	input wire poll,
	input wire jstkPkg::spiByteRsp rsp,
	output jstkPkg::spiByteReq req,
	output logic SS,
	output jstkPkg::jstkSample sample
);

	typedef enum logic [1:0] {
		stIdle,
		stReq,
		stWait,
		stClose
	} frameState;

	frameState state;
	logic [$clog2(jstkPkg::frameBytes)-1:0] byteCnt;    // Slot of the byte in flight
	logic [jstkPkg::frameBytes-1:0][jstkPkg::bitsPerByte-1:0] rxBuf;
	logic startReg;
	logic lastByte;

	always_comb lastByte = (32'(byteCnt) == jstkPkg::frameBytes - 1);

	// ==================================================
	// Frame sequencer
	// ==================================================
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state <= stIdle;
			byteCnt <= '0;
			SS <= 1'b1;                                   // Slave deselected
			startReg <= 1'b0;
		end else begin
			startReg <= 1'b0;                             // Start is a pulse
			case (state)
				stIdle: begin
					if (poll) begin                           // Polls only honoured here
						SS <= 1'b0;
						byteCnt <= '0;
						state <= stReq;
					end
				end
				stReq: begin
					if (!rsp.busy) begin                      // First byte of the frame
						startReg <= 1'b1;
						state <= stWait;
					end
				end
				stWait: begin
					if (rsp.done) begin
						if (lastByte) begin
							SS <= 1'b1;                            // Valid shows at this edge too
							state <= stClose;
						end else begin
							byteCnt <= byteCnt + 1'b1;
							startReg <= 1'b1;                      // Next byte right after done
						end
					end
				end
				stClose: state <= stIdle;
				default: state <= stIdle;
			endcase
		end
	end

	// Received bytes by slot
	always_ff @(posedge CLK) begin
		if (state == stWait && rsp.done) begin
			rxBuf[byteCnt] <= rsp.rxByte;
		end
	end

	always_comb begin
		req.start = startReg;
		req.txByte = jstkPkg::jstkCmd;               // Same command in every slot
		sample.xPos = {rxBuf[1][1:0], rxBuf[0]};     // X high bits, X low byte
		sample.yPos = {rxBuf[3][1:0], rxBuf[2]};     // Y high bits, Y low byte
		sample.button = rxBuf[4][1];                 // Only bit 1 of button byte
		sample.valid = (state == stClose);
	end

endmodule

`default_nettype wire

// ==== source/steerClassifier.sv ====
`timescale 1ns/1ps
`default_nettype none

// Joystick position to steering direction
module steerClassifier (
	input wire CLK,
	input wire RST,
	input wire jstkPkg::jstkSample sample,
	output steerPkg::steerDir DIRECTION,
	output logic BUTTON
);

	logic inBand;                                    // Y inside side-steer band

	always_comb begin
		inBand = (32'(sample.yPos) >= steerPkg::bandMinY) &&
			(32'(sample.yPos) <= steerPkg::bandMaxY);
	end

	// Rules in priority order, dead zone keeps last direction
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			DIRECTION <= steerPkg::straight;
			BUTTON <= 1'b0;
		end else if (sample.valid) begin
			BUTTON <= sample.button;
			if (32'(sample.xPos) >= steerPkg::leftMinX && inBand) begin
				DIRECTION <= steerPkg::left;
			end else if (32'(sample.xPos) <= steerPkg::rightMaxX && inBand) begin
				DIRECTION <= steerPkg::right;
			end else if (32'(sample.yPos) < steerPkg::bandMinY) begin
				DIRECTION <= steerPkg::straight;
			end else if (32'(sample.yPos) > steerPkg::bandMaxY) begin
				DIRECTION <= steerPkg::back;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/joystickSteer.sv ====
`timescale 1ns/1ps
`default_nettype none

// Joystick steering top
module joystickSteer (
	input wire CLK,
	input wire RST,
	input wire MISO,
	output logic SS,
	output logic SCLK,
	output logic MOSI,
	output steerPkg::steerDir DIRECTION,
	output logic BUTTON
);

	logic poll;                                      // Frame trigger
	jstkPkg::spiByteReq byteReq;
	jstkPkg::spiByteRsp byteRsp;
	jstkPkg::jstkSample sample;

	// ==================================================
	// Frame path
	// ==================================================
	pollTimer u_pollTimer (
		.CLK(CLK),
		.RST(RST),
		.poll(poll)
	);

	jstkFrameCtrl u_jstkFrameCtrl (
		.CLK(CLK),
		.RST(RST),
		.poll(poll),
		.rsp(byteRsp),
		.req(byteReq),
		.SS(SS),
		.sample(sample)
	);

	spiByteEngine u_spiByteEngine (
		.CLK(CLK),
		.RST(RST),
		.req(byteReq),
		.MISO(MISO),
		.rsp(byteRsp),
		.SCLK(SCLK),
		.MOSI(MOSI)
	);

	// Direction and button outputs
	steerClassifier u_steerClassifier (
		.CLK(CLK),
		.RST(RST),
		.sample(sample),
		.DIRECTION(DIRECTION),
		.BUTTON(BUTTON)
	);

endmodule

`default_nettype wire

// ==== sim/joystickSteer_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

// SPI pin and output timing checks
module joystickSteerChk (
	input wire CLK,
	input wire RST,
	input wire SS,
	input wire SCLK,
	input wire MOSI,
	input wire steerPkg::steerDir DIRECTION,
	input wire BUTTON
);

	// ==================================================
	// SPI pins
	// ==================================================
	// Clock parked between frames
	sclkIdle: assert property (@(posedge CLK) disable iff (RST) SS |-> !SCLK)
		else $error("SCLK high while SS deselected");

	mosiHold: assert property (@(posedge CLK) disable iff (RST) SCLK |-> $stable(MOSI))
		else $error("MOSI changed while SCLK high");   // Mode 0, slave samples on rise

	// ==================================================
	// Output update point
	// ==================================================
	// Only the cycle after SS rises
	outUpdate: assert property (@(posedge CLK) disable iff (RST)
		(!$stable(DIRECTION) || !$stable(BUTTON)) |-> ($past(SS) && !$past(SS, 2)))
		else $error("DIRECTION or BUTTON changed outside the cycle after SS rise");

endmodule

bind joystickSteer joystickSteerChk u_joystickSteerChk (
	.CLK(CLK),
	.RST(RST),
	.SS(SS),
	.SCLK(SCLK),
	.MOSI(MOSI),
	.DIRECTION(DIRECTION),
	.BUTTON(BUTTON)
);

`default_nettype wire

// ==== sim/tbJoystickSteer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbJoystickSteer;

	localparam logic [7:0] cmdByte = 8'h80;         // LEDs-off command seen on MOSI
	localparam int frameLen = 5;                    // Bytes per frame

	logic CLK;
	logic RST;
	logic MISO;
	logic SS;
	logic SCLK;
	logic MOSI;
	steerPkg::steerDir DIRECTION;
	logic BUTTON;

	logic [39:0] vecFrame[$];                       // Slave bytes with byte 0 in top bits
	steerPkg::steerDir vecDir[$];
	logic vecBtn[$];
	int errorCount = 0;
	int testCount = 0;
	int timeoutLimit = 4 * jstkPkg::pollPeriod;     // Replaced once vectors are known
	int cycles = 0;

	joystickSteer u_joystickSteer (
		.CLK(CLK),
		.RST(RST),
		.MISO(MISO),
		.SS(SS),
		.SCLK(SCLK),
		.MOSI(MOSI),
		.DIRECTION(DIRECTION),
		.BUTTON(BUTTON)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;                      // 40 ns period
	end

	// ==================================================
	// Helpers and compare tasks
	// ==================================================
	task automatic waitCycle();
		@(posedge CLK);
		#1;                                          // Outputs settled and inputs driven here
	endtask

	task automatic checkDir(input string name, input steerPkg::steerDir actual,
		input steerPkg::steerDir expected);
		if (actual !== expected) begin
			$display("** Error at %0d ns: %s expected %s, got %s", $time, name,
				expected.name(), actual.name());
			errorCount++;
		end
	endtask

	task automatic checkBit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("** Error at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkByte(input string name, input logic [jstkPkg::bitsPerByte-1:0] actual,
		input logic [jstkPkg::bitsPerByte-1:0] expected);
		if (actual !== expected) begin
			$display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	// Lines starting with # are headers
	task automatic readVectors();
		int fd;
		int n;
		int dirNum;
		int btnNum;
		string line;
		logic [7:0] b0, b1, b2, b3, b4;
		fd = $fopen("sim/joystickSteer_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open sim/joystickSteer_vectors.txt");
			errorCount++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line.substr(0, 0) != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %d %d", b0, b1, b2, b3, b4, dirNum, btnNum);
					if (n == 7) begin
						vecFrame.push_back({b0, b1, b2, b3, b4});
						vecDir.push_back(steerPkg::steerDir'(dirNum[1:0]));
						vecBtn.push_back(btnNum[0]);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// ==================================================
	// SPI slave model for one frame
	// ==================================================
	task automatic runFrame(input logic [39:0] frame, input steerPkg::steerDir expDir,
		input logic expBtn);
		logic [39:0] misoSr;
		logic [7:0] mosiSr;
		logic prevSclk;
		int bitCnt;
		int byteCnt;
		int errsBefore;
		errsBefore = errorCount;
		misoSr = frame;
		mosiSr = '0;
		bitCnt = 0;
		byteCnt = 0;
		while (SS) begin                             // Poll timer opens the frame
			waitCycle();
		end
		MISO = misoSr[39];                           // Bit 7 of byte 0 on SS fall
		prevSclk = SCLK;
		while (!SS) begin
			waitCycle();
			if (!prevSclk && SCLK) begin               // Rising edge
				mosiSr = {mosiSr[6:0], MOSI};
				bitCnt++;
				if (bitCnt == 8) begin
					checkByte($sformatf("MOSI byte %0d", byteCnt), mosiSr, cmdByte);
					byteCnt++;
					bitCnt = 0;
				end
			end else if (prevSclk && !SCLK) begin      // Next bit out after falling edge
				misoSr = {misoSr[38:0], 1'b0};
				MISO = misoSr[39];
			end
			prevSclk = SCLK;
		end
		if (byteCnt != frameLen || bitCnt != 0) begin
			$display("Frame ended after %0d bytes and %0d bits instead of %0d full bytes",
				byteCnt, bitCnt, frameLen);
			errorCount++;
		end
		waitCycle();                                 // Outputs register after SS rise
		checkDir("DIRECTION", DIRECTION, expDir);
		checkBit("BUTTON", BUTTON, expBtn);
		testCount++;
		$display("Test %0d: slave bytes %h, direction %s, button %b: %s", testCount, frame,
			expDir.name(), expBtn, (errorCount == errsBefore) ? "pass" : "fail");
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		int errsBefore;
		int unsigned idle;
		void'($urandom(24));
		RST = 1'b1;
		MISO = 1'b0;
		readVectors();
		timeoutLimit = (vecFrame.size() + 2) * 2 * jstkPkg::pollPeriod;
		repeat (2) @(posedge CLK);
		#1;
		RST = 1'b0;

		// Reset state
		errsBefore = errorCount;
		checkBit("SS", SS, 1'b1);
		checkBit("SCLK", SCLK, 1'b0);
		checkBit("MOSI", MOSI, 1'b0);
		checkBit("BUTTON", BUTTON, 1'b0);
		checkDir("DIRECTION", DIRECTION, steerPkg::straight);
		testCount++;
		$display("Test %0d: reset state: %s", testCount,
			(errorCount == errsBefore) ? "pass" : "fail");

		while (vecFrame.size() > 0) begin            // Frames come from the poll timer alone
			runFrame(vecFrame.pop_front(), vecDir.pop_front(), vecBtn.pop_front());
		end

		idle = 2 + $urandom % 6;                     // Idle tail without effect on results
		repeat (idle) begin
			waitCycle();
		end
		$display("Tests: %0d, errors: %0d", testCount, errorCount);
		if (errorCount == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// Watchdog on CLK cycles
	initial begin
		while (cycles < timeoutLimit) begin
			@(posedge CLK);
			cycles++;
		end
		$display("Timeout: run still going after %0d clock cycles", cycles);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
source/jstkPkg.sv
source/steerPkg.sv
source/pollTimer.sv
source/spiByteEngine.sv
source/jstkFrameCtrl.sv
source/steerClassifier.sv
source/joystickSteer.sv
sim/joystickSteer_chk.sv
sim/tbJoystickSteer.sv

// ==== Makefile ====
# Verilator flow for the joystick steering testbench

VERILATOR ?= verilator
TOP ?= tbJoystickSteer
LOG ?= sim.log
FLAGS ?= --timing --assert
OBJDIR ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f tb.f

# Fails on a nonzero exit status or on the fail line in the log
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f tb.f
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qx "Finished with errors" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== sim/joystickSteer_vectors.txt ====
# slave bytes xLo xHi yLo yHi buttons (hex), expected direction and button
# direction 0 straight, 1 left, 2 back, 3 right; button 0 or 1
58 02 F4 01 02 1 1
F4 01 F4 01 00 1 0
90 01 F4 01 04 3 0
F4 01 F4 01 FD 3 0
F4 01 64 00 02 0 1
F4 01 84 03 03 2 1
26 02 40 01 00 1 0
C2 01 D0 02 00 3 0
F4 01 3F 01 00 0 0
25 02 F4 01 02 0 1
F4 01 D1 02 00 2 0
C3 01 58 02 02 2 1
00 00 00 00 00 0 0
FF 03 D0 02 FF 1 1
